/* axi_read_xbar.f */
source/axi_pkg.sv
source/ar_channel.sv
source/r_channel.sv
source/default_slave.sv
source/axi_read_xbar.sv
tests/tb_clock.sv
tests/axi_read_xbar_props.sv
tests/axi_read_xbar_tb.sv

/* Bender.yml */
package:
  name: axi_read_xbar

sources:
  - source/axi_pkg.sv
  - source/ar_channel.sv
  - source/r_channel.sv
  - source/default_slave.sv
  - source/axi_read_xbar.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/axi_read_xbar_props.sv
      - tests/axi_read_xbar_tb.sv

/* tests/axi_read_xbar_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Memory model: data of each beat is the burst address plus the beat index
module burst_slave #(
  parameter int DATA_W = 32
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [axi_pkg::IDS_BITS-1:0]  arid,
  input  logic [axi_pkg::ADDR_BITS-1:0] araddr,
  input  logic [axi_pkg::LEN_BITS-1:0]  arlen,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [axi_pkg::IDS_BITS-1:0]  rid,
  output logic [DATA_W-1:0]             rdata,
  output logic [1:0]                    rresp,
  output logic                          rlast,
  output logic                          rvalid,
  input  logic                          rready
);

  logic [axi_pkg::IDS_BITS-1:0]  id_s;
  logic [axi_pkg::ADDR_BITS-1:0] base, addr_s;
  logic [axi_pkg::LEN_BITS-1:0]  len, len_s;
  logic                          ar_hs, r_hs, in_reset;
  int                            beat;

  initial begin
    arready = 1'b0;
    rid     = '0;
    rdata   = '0;
    rresp   = axi_pkg::RESP_OKAY;
    rlast   = 1'b0;
    rvalid  = 1'b0;
    base    = '0;
    len     = '0;
    beat    = 0;
  end

  always @(posedge clk) begin
    in_reset = !rstn;  // Sampled at the edge, applied 1 ns later
    ar_hs    = arvalid & arready;
    r_hs     = rvalid & rready;
    id_s     = arid;
    addr_s   = araddr;
    len_s    = arlen;
    #1;
    if (in_reset) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rlast   = 1'b0;
    end else if (ar_hs) begin
      base    = addr_s;
      len     = len_s;
      beat    = 0;
      rid     = id_s;
      rdata   = addr_s;
      rlast   = (len_s == 0);
      rvalid  = 1'b1;
      arready = 1'b0;  // One burst at a time
    end else if (r_hs) begin
      if (rlast) begin
        rvalid  = 1'b0;
        rlast   = 1'b0;
        arready = 1'b1;
      end else begin
        beat++;
        rdata = base + beat;
        rlast = (beat == len);
      end
    end else if (!rvalid) begin
      arready = 1'b1;
    end
  end

endmodule

module axi_read_xbar_tb;

  localparam int DATA_W  = 32;
  localparam int TIMEOUT = 200;  // Cycles per wait

  localparam logic [2:0] M0_SIZE  = 3'd2;
  localparam logic [2:0] M1_SIZE  = 3'd3;
  localparam logic [1:0] M0_BURST = 2'b01;  // INCR
  localparam logic [1:0] M1_BURST = 2'b01;

  logic clk, rstn;

  logic [axi_pkg::ID_BITS-1:0]   m0_arid, m1_arid, m0_rid, m1_rid;
  logic [axi_pkg::IDS_BITS-1:0]  s0_arid, s1_arid, s0_rid, s1_rid;
  logic [axi_pkg::ADDR_BITS-1:0] m0_araddr, m1_araddr, s0_araddr, s1_araddr;
  logic [axi_pkg::LEN_BITS-1:0]  m0_arlen, m1_arlen, s0_arlen, s1_arlen;
  logic [axi_pkg::SIZE_BITS-1:0] m0_arsize, m1_arsize, s0_arsize, s1_arsize;
  logic [1:0]                    m0_arburst, m1_arburst, s0_arburst, s1_arburst;
  logic [DATA_W-1:0]             m0_rdata, m1_rdata, s0_rdata, s1_rdata;
  logic [1:0]                    m0_rresp, m1_rresp, s0_rresp, s1_rresp;
  logic m0_arvalid, m0_arready, m0_rlast, m0_rvalid, m0_rready;
  logic m1_arvalid, m1_arready, m1_rlast, m1_rvalid, m1_rready;
  logic s0_arvalid, s0_arready, s0_rlast, s0_rvalid, s0_rready;
  logic s1_arvalid, s1_arready, s1_rlast, s1_rvalid, s1_rready;

  int errors = 0;
  int seed   = 70;
  int s0_vld_cycles = 0;
  int s1_vld_cycles = 0;
  logic [axi_pkg::ADDR_BITS-1:0] s0_addr_log[$];
  logic [axi_pkg::IDS_BITS-1:0]  s0_id_log[$];

  tb_clock u_clock (.clk(clk));

  axi_read_xbar #(.DATA_W(DATA_W)) dut0 (.*);

  burst_slave #(.DATA_W(DATA_W)) u_slave0 (
    .clk, .rstn, .arid(s0_arid), .araddr(s0_araddr), .arlen(s0_arlen),
    .arvalid(s0_arvalid), .arready(s0_arready), .rid(s0_rid), .rdata(s0_rdata),
    .rresp(s0_rresp), .rlast(s0_rlast), .rvalid(s0_rvalid), .rready(s0_rready)
  );

  burst_slave #(.DATA_W(DATA_W)) u_slave1 (
    .clk, .rstn, .arid(s1_arid), .araddr(s1_araddr), .arlen(s1_arlen),
    .arvalid(s1_arvalid), .arready(s1_arready), .rid(s1_rid), .rdata(s1_rdata),
    .rresp(s1_rresp), .rlast(s1_rlast), .rvalid(s1_rvalid), .rready(s1_rready)
  );

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Size and burst type come from the master named by the ID tag
  task automatic check_ar_attr(input string port, input logic tag,
                               input logic [2:0] size, input logic [1:0] burst);
    logic [2:0] exp_size;
    logic [1:0] exp_burst;
    exp_size  = tag ? M1_SIZE : M0_SIZE;
    exp_burst = tag ? M1_BURST : M0_BURST;
    if (size !== exp_size) report_value({port, "_arsize"}, size, exp_size);
    if (burst !== exp_burst) report_value({port, "_arburst"}, burst, exp_burst);
  endtask

  // Slave-side address monitor
  always @(posedge clk) begin
    if (s0_arvalid) s0_vld_cycles++;
    if (s1_arvalid) s1_vld_cycles++;
    if (s0_arvalid && s0_arready) begin
      s0_addr_log.push_back(s0_araddr);
      s0_id_log.push_back(s0_arid);
      check_ar_attr("s0", s0_arid[axi_pkg::IDS_BITS-1], s0_arsize, s0_arburst);
    end
    if (s1_arvalid && s1_arready) begin
      check_ar_attr("s1", s1_arid[axi_pkg::IDS_BITS-1], s1_arsize, s1_arburst);
    end
  end

  task automatic drive_ar(input int m, input logic valid, input logic [3:0] id,
                          input logic [31:0] addr, input logic [3:0] len);
    if (m == 0) begin
      m0_arvalid = valid;
      m0_arid    = id;
      m0_araddr  = addr;
      m0_arlen   = len;
    end else begin
      m1_arvalid = valid;
      m1_arid    = id;
      m1_araddr  = addr;
      m1_arlen   = len;
    end
  endtask

  task automatic drive_rready(input int m, input logic value);
    if (m == 0) m0_rready = value;
    else m1_rready = value;
  endtask

  // Called 1 ns after an edge, returns 1 ns after the handshake edge
  task automatic send_addr(input int m, input logic [3:0] id, input logic [31:0] addr,
                           input logic [3:0] len, output time hs_time);
    int   cycles;
    logic rdy;
    cycles  = 0;
    rdy     = 1'b0;
    hs_time = 0;
    drive_ar(m, 1'b1, id, addr, len);
    while (!rdy && cycles <= TIMEOUT) begin
      @(posedge clk);
      rdy = (m == 0) ? m0_arready : m1_arready;
      cycles++;
    end
    if (rdy) hs_time = $time;
    else report_problem($sformatf("master %0d address handshake timed out", m));
    #1;
    drive_ar(m, 1'b0, '0, '0, '0);
  endtask

  task automatic read_burst(input int m, input logic [3:0] id, input logic [31:0] addr,
                            input int len, input bit unmapped, input int stall,
                            output time done_time);
    int          beat, idle, held;
    bit          done, rdy;
    logic [3:0]  rid;
    logic [31:0] rdata, exp_data, held_data;
    logic [1:0]  rresp, exp_resp;
    logic        rlast, rvalid, held_last;
    string       pfx;
    beat      = 0;
    idle      = 0;
    held      = 0;
    done      = 1'b0;
    done_time = 0;
    pfx       = (m == 0) ? "m0" : "m1";
    exp_resp  = unmapped ? axi_pkg::RESP_DECERR : axi_pkg::RESP_OKAY;
    rdy       = (stall == 0);
    drive_rready(m, rdy);
    while (!done) begin
      @(posedge clk);
      if (m == 0) begin
        {rvalid, rid, rdata, rresp, rlast} = {m0_rvalid, m0_rid, m0_rdata, m0_rresp, m0_rlast};
      end else begin
        {rvalid, rid, rdata, rresp, rlast} = {m1_rvalid, m1_rid, m1_rdata, m1_rresp, m1_rlast};
      end
      if (rvalid && rdy) begin
        exp_data = unmapped ? 32'h0 : addr + beat;
        if (rid !== id) report_value({pfx, "_rid"}, rid, id);
        if (rdata !== exp_data) report_value({pfx, "_rdata"}, rdata, exp_data);
        if (rresp !== exp_resp) report_value({pfx, "_rresp"}, rresp, exp_resp);
        if (rlast !== (beat == len)) report_value({pfx, "_rlast"}, rlast, beat == len);
        beat++;
        idle = 0;
        if (rlast || beat > len) begin
          done      = 1'b1;
          done_time = $time;
        end
      end else if (rvalid) begin
        if (held == 0) begin
          held_data = rdata;
          held_last = rlast;
        end else begin
          if (rdata !== held_data) report_value({pfx, "_rdata"}, rdata, held_data);
          if (rlast !== held_last) report_value({pfx, "_rlast"}, rlast, held_last);
        end
        held++;
        if (held >= stall) begin
          #1;
          rdy = 1'b1;
          drive_rready(m, 1'b1);
        end
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          report_problem($sformatf("no read beat on master %0d after %0d cycles", m, idle));
          done = 1'b1;
        end
      end
    end
    if (beat != len + 1) begin
      report_problem($sformatf("master %0d got %0d beats, expected %0d", m, beat, len + 1));
    end
    #1;
    drive_rready(m, 1'b0);
  endtask

  task automatic read_s0_single();
    logic [3:0]  id, len;
    logic [31:0] addr;
    time         t_hs, t_done;
    id   = $random(seed);
    len  = $random(seed);
    addr = $random(seed) & 32'h0000_fff0;
    s0_addr_log.delete();
    s0_id_log.delete();
    send_addr(0, id, addr, len, t_hs);
    read_burst(0, id, addr, len, 1'b0, 0, t_done);
    if (s0_addr_log.size() != 1) begin
      report_problem("slave 0 did not see exactly one address");
    end else begin
      if (s0_addr_log[0] !== addr) report_value("s0_araddr", s0_addr_log[0], addr);
      if (s0_id_log[0] !== {1'b0, id}) report_value("s0_arid", s0_id_log[0], {1'b0, id});
    end
  endtask

  task automatic read_s1_backpressure();
    logic [3:0]  id, len;
    logic [31:0] addr;
    time         t_hs, t_done;
    id   = $random(seed);
    len  = $random(seed) & 7;
    addr = 32'h0001_0000 + ($random(seed) & 32'h0000_fff0);
    send_addr(1, id, addr, len, t_hs);
    read_burst(1, id, addr, len, 1'b0, 5, t_done);
  endtask

  task automatic check_priority();
    logic [3:0]  id0, id1, len0, len1;
    logic [31:0] addr0, addr1;
    time         t0, t1, d0, d1;
    id0   = $random(seed);
    id1   = $random(seed);
    len0  = $random(seed) & 7;
    len1  = $random(seed) & 7;
    addr0 = $random(seed) & 32'h0000_fff0;
    addr1 = 32'h0001_0000 + ($random(seed) & 32'h0000_fff0);
    fork
      send_addr(0, id0, addr0, len0, t0);
      send_addr(1, id1, addr1, len1, t1);
    join
    if (t1 <= t0) report_problem("master 1 address was not held back behind master 0");
    fork
      read_burst(0, id0, addr0, len0, 1'b0, 0, d0);
      read_burst(1, id1, addr1, len1, 1'b0, 0, d1);
    join
  endtask

  task automatic read_unmapped();
    logic [3:0]  id, len;
    logic [31:0] addr;
    time         t_hs, t_done;
    int          v0, v1;
    id   = $random(seed);
    len  = $random(seed);
    addr = 32'h0040_0000 | ($random(seed) & 32'h0000_fff0);
    v0   = s0_vld_cycles;
    v1   = s1_vld_cycles;
    send_addr(0, id, addr, len, t_hs);
    read_burst(0, id, addr, len, 1'b1, 0, t_done);
    if (s0_vld_cycles != v0) report_problem("unmapped read raised arvalid on slave 0");
    if (s1_vld_cycles != v1) report_problem("unmapped read raised arvalid on slave 1");
  endtask

  task automatic check_outstanding_locks();
    logic [3:0]  id_a, id_b, id_c, len_a, len_b, len_c;
    logic [31:0] addr_a, addr_b, addr_c;
    time         t_a, t_b, t_c, d_a, d_b, d_c;
    int          v0;
    id_a   = $random(seed);
    id_b   = $random(seed);
    id_c   = $random(seed);
    len_a  = $random(seed) & 7;
    len_b  = $random(seed) & 7;
    len_c  = $random(seed) & 7;
    addr_a = $random(seed) & 32'h0000_fff0;
    addr_b = 32'h0001_0000 + ($random(seed) & 32'h0000_fff0);  // Other slave for M0
    addr_c = $random(seed) & 32'h0000_fff0;  // Same slave as the first M0 read
    send_addr(0, id_a, addr_a, len_a, t_a);
    v0 = s0_vld_cycles;
    fork
      read_burst(0, id_a, addr_a, len_a, 1'b0, 6, d_a);
      send_addr(0, id_b, addr_b, len_b, t_b);
      send_addr(1, id_c, addr_c, len_c, t_c);
    join
    if (t_b <= d_a) report_problem("master 0 got arready before its RLAST handshake");
    if (t_c <= d_a) report_problem("master 1 handshake came before slave 0 was free");
    if (s0_vld_cycles - v0 != 1) report_problem("master 1 request reached busy slave 0");
    if (s0_addr_log[$] !== addr_c) report_value("s0_araddr", s0_addr_log[$], addr_c);
    if (s0_id_log[$] !== {1'b1, id_c}) report_value("s0_arid", s0_id_log[$], {1'b1, id_c});
    fork
      read_burst(0, id_b, addr_b, len_b, 1'b0, 0, d_b);
      read_burst(1, id_c, addr_c, len_c, 1'b0, 0, d_c);
    join
  endtask

  initial begin
    rstn = 1'b0;
    m0_arsize  = M0_SIZE;
    m1_arsize  = M1_SIZE;
    m0_arburst = M0_BURST;
    m1_arburst = M1_BURST;
    drive_ar(0, 1'b0, '0, '0, '0);
    drive_ar(1, 1'b0, '0, '0, '0);
    m0_rready = 1'b0;
    m1_rready = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    read_s0_single();
    read_s1_backpressure();
    check_priority();
    read_unmapped();
    check_outstanding_locks();
    repeat (2) @(posedge clk);
    errors = errors + dut0.u_props.fail_count;
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/axi_read_xbar_props.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_xbar_props #(
  parameter int DATA_W = 32
) (
  input logic              clk,
  input logic              rstn,
  input logic              s0_arvalid,
  input logic              s1_arvalid,
  input logic              s2_arvalid,
  input logic              m0_arvalid,
  input logic              m0_arready,
  input logic              m0_rvalid,
  input logic              m0_rready,
  input logic              m0_rlast,
  input logic [DATA_W-1:0] m0_rdata,
  input logic              m1_arvalid,
  input logic              m1_arready,
  input logic              m1_rvalid,
  input logic              m1_rready,
  input logic              m1_rlast
);

  int   fail_count = 0;  // Read by the testbench at the end
  logic m0_busy, m1_busy;

  // Address handshake up to the RLAST handshake
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m0_busy <= 1'b0;
      m1_busy <= 1'b0;
    end else begin
      if (m0_arvalid && m0_arready) m0_busy <= 1'b1;
      else if (m0_rvalid && m0_rready && m0_rlast) m0_busy <= 1'b0;
      if (m1_arvalid && m1_arready) m1_busy <= 1'b1;
      else if (m1_rvalid && m1_rready && m1_rlast) m1_busy <= 1'b0;
    end
  end

  one_target: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({s0_arvalid, s1_arvalid, s2_arvalid}))
    else begin
      fail_count++;
      $error("More than one slave arvalid high");
    end

  m0_beat_held: assert property (@(posedge clk) disable iff (!rstn)
    m0_rvalid && !m0_rready |=> m0_rvalid && $stable(m0_rdata) && $stable(m0_rlast))
    else begin
      fail_count++;
      $error("m0 read beat changed while stalled");
    end

  m0_one_read: assert property (@(posedge clk) disable iff (!rstn) m0_busy |-> !m0_arready)
    else begin
      fail_count++;
      $error("m0_arready high with a read outstanding");
    end

  m1_one_read: assert property (@(posedge clk) disable iff (!rstn) m1_busy |-> !m1_arready)
    else begin
      fail_count++;
      $error("m1_arready high with a read outstanding");
    end

endmodule

bind axi_read_xbar axi_read_xbar_props #(.DATA_W(DATA_W)) u_props (.*);

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

/* source/axi_read_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_xbar #(
  parameter int DATA_W = 32
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [axi_pkg::ID_BITS-1:0]   m0_arid,
  input  logic [axi_pkg::ADDR_BITS-1:0] m0_araddr,
  input  logic [axi_pkg::LEN_BITS-1:0]  m0_arlen,
  input  logic [axi_pkg::SIZE_BITS-1:0] m0_arsize,
  input  logic [1:0]                    m0_arburst,
  input  logic                          m0_arvalid,
  output logic                          m0_arready,
  output logic [axi_pkg::ID_BITS-1:0]   m0_rid,
  output logic [DATA_W-1:0]             m0_rdata,
  output logic [1:0]                    m0_rresp,
  output logic                          m0_rlast,
  output logic                          m0_rvalid,
  input  logic                          m0_rready,
  input  logic [axi_pkg::ID_BITS-1:0]   m1_arid,
  input  logic [axi_pkg::ADDR_BITS-1:0] m1_araddr,
  input  logic [axi_pkg::LEN_BITS-1:0]  m1_arlen,
  input  logic [axi_pkg::SIZE_BITS-1:0] m1_arsize,
  input  logic [1:0]                    m1_arburst,
  input  logic                          m1_arvalid,
  output logic                          m1_arready,
  output logic [axi_pkg::ID_BITS-1:0]   m1_rid,
  output logic [DATA_W-1:0]             m1_rdata,
  output logic [1:0]                    m1_rresp,
  output logic                          m1_rlast,
  output logic                          m1_rvalid,
  input  logic                          m1_rready,
  output logic [axi_pkg::IDS_BITS-1:0]  s0_arid,
  output logic [axi_pkg::ADDR_BITS-1:0] s0_araddr,
  output logic [axi_pkg::LEN_BITS-1:0]  s0_arlen,
  output logic [axi_pkg::SIZE_BITS-1:0] s0_arsize,
  output logic [1:0]                    s0_arburst,
  output logic                          s0_arvalid,
  input  logic                          s0_arready,
  input  logic [axi_pkg::IDS_BITS-1:0]  s0_rid,
  input  logic [DATA_W-1:0]             s0_rdata,
  input  logic [1:0]                    s0_rresp,
  input  logic                          s0_rlast,
  input  logic                          s0_rvalid,
  output logic                          s0_rready,
  output logic [axi_pkg::IDS_BITS-1:0]  s1_arid,
  output logic [axi_pkg::ADDR_BITS-1:0] s1_araddr,
  output logic [axi_pkg::LEN_BITS-1:0]  s1_arlen,
  output logic [axi_pkg::SIZE_BITS-1:0] s1_arsize,
  output logic [1:0]                    s1_arburst,
  output logic                          s1_arvalid,
  input  logic                          s1_arready,
  input  logic [axi_pkg::IDS_BITS-1:0]  s1_rid,
  input  logic [DATA_W-1:0]             s1_rdata,
  input  logic [1:0]                    s1_rresp,
  input  logic                          s1_rlast,
  input  logic                          s1_rvalid,
  output logic                          s1_rready
);

  // Default slave side
  logic [axi_pkg::IDS_BITS-1:0] s2_arid;
  logic [axi_pkg::LEN_BITS-1:0] s2_arlen;
  logic                         s2_arvalid, s2_arready;
  logic [axi_pkg::IDS_BITS-1:0] s2_rid;
  logic [DATA_W-1:0]            s2_rdata;
  logic [1:0]                   s2_rresp;
  logic                         s2_rlast, s2_rvalid, s2_rready;

  logic m0_r_done, m1_r_done;  // RLAST handshakes back to the locks
  logic s0_r_done, s1_r_done, s2_r_done;

  // Default slave ignores address, size and burst type
  ar_channel u_ar_channel (
    .s2_araddr  (),
    .s2_arsize  (),
    .s2_arburst (),
    .*
  );

  r_channel #(.DATA_W(DATA_W)) u_r_channel (.*);

  default_slave #(.DATA_W(DATA_W)) u_default_slave (.*);

endmodule

`default_nettype wire

/* source/default_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module default_slave #(
  parameter int DATA_W = 32
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic [axi_pkg::IDS_BITS-1:0] s2_arid,
  input  logic [axi_pkg::LEN_BITS-1:0] s2_arlen,
  input  logic                         s2_arvalid,
  output logic                         s2_arready,
  output logic [axi_pkg::IDS_BITS-1:0] s2_rid,
  output logic [DATA_W-1:0]            s2_rdata,
  output logic [1:0]                   s2_rresp,
  output logic                         s2_rlast,
  output logic                         s2_rvalid,
  input  logic                         s2_rready
);

  axi_pkg::ds_state_t state;

  logic [axi_pkg::LEN_BITS-1:0] beats_left;  // Beats after the current one
  logic [axi_pkg::IDS_BITS-1:0] id_q;

  assign s2_arready = (state == axi_pkg::DS_IDLE);
  assign s2_rvalid  = (state == axi_pkg::DS_BURST);
  assign s2_rid     = id_q;
  assign s2_rdata   = '0;
  assign s2_rresp   = axi_pkg::RESP_DECERR;
  assign s2_rlast   = s2_rvalid & (beats_left == '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= axi_pkg::DS_IDLE;
      beats_left <= '0;
    end else begin
      case (state)
        axi_pkg::DS_IDLE: begin
          if (s2_arvalid) begin
            state      <= axi_pkg::DS_BURST;
            beats_left <= s2_arlen;
          end
        end
        default: begin
          if (s2_rready) begin
            if (beats_left == '0) state <= axi_pkg::DS_IDLE;
            else beats_left <= beats_left - 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s2_arvalid && s2_arready) id_q <= s2_arid;
  end

endmodule

`default_nettype wire

/* source/r_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module r_channel #(
  parameter int DATA_W = 32
) (
  input  logic [axi_pkg::IDS_BITS-1:0] s0_rid,
  input  logic [DATA_W-1:0]            s0_rdata,
  input  logic [1:0]                   s0_rresp,
  input  logic                         s0_rlast,
  input  logic                         s0_rvalid,
  output logic                         s0_rready,
  input  logic [axi_pkg::IDS_BITS-1:0] s1_rid,
  input  logic [DATA_W-1:0]            s1_rdata,
  input  logic [1:0]                   s1_rresp,
  input  logic                         s1_rlast,
  input  logic                         s1_rvalid,
  output logic                         s1_rready,
  input  logic [axi_pkg::IDS_BITS-1:0] s2_rid,
  input  logic [DATA_W-1:0]            s2_rdata,
  input  logic [1:0]                   s2_rresp,
  input  logic                         s2_rlast,
  input  logic                         s2_rvalid,
  output logic                         s2_rready,
  output logic [axi_pkg::ID_BITS-1:0]  m0_rid,
  output logic [DATA_W-1:0]            m0_rdata,
  output logic [1:0]                   m0_rresp,
  output logic                         m0_rlast,
  output logic                         m0_rvalid,
  input  logic                         m0_rready,
  output logic [axi_pkg::ID_BITS-1:0]  m1_rid,
  output logic [DATA_W-1:0]            m1_rdata,
  output logic [1:0]                   m1_rresp,
  output logic                         m1_rlast,
  output logic                         m1_rvalid,
  input  logic                         m1_rready,
  output logic                         m0_r_done,
  output logic                         m1_r_done,
  output logic                         s0_r_done,
  output logic                         s1_r_done,
  output logic                         s2_r_done
);

  logic [axi_pkg::IDS_BITS-1:0] rid_s   [3];
  logic [DATA_W-1:0]            rdata_s [3];
  logic [1:0]                   rresp_s [3];
  logic [2:0]                   rlast_s, rvalid_s;

  logic [axi_pkg::ID_BITS-1:0]  rid_m   [2];
  logic [DATA_W-1:0]            rdata_m [2];
  logic [1:0]                   rresp_m [2];
  logic [1:0]                   rlast_m, rvalid_m;
  logic [2:0]                   route   [2];  // route[m][k]: slave k answers master m

  assign rid_s    = '{s0_rid, s1_rid, s2_rid};
  assign rdata_s  = '{s0_rdata, s1_rdata, s2_rdata};
  assign rresp_s  = '{s0_rresp, s1_rresp, s2_rresp};
  assign rlast_s  = {s2_rlast, s1_rlast, s0_rlast};
  assign rvalid_s = {s2_rvalid, s1_rvalid, s0_rvalid};

  // At most one slave holds a burst for a given master
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      rid_m[m]    = '0;
      rdata_m[m]  = '0;
      rresp_m[m]  = '0;
      rlast_m[m]  = 1'b0;
      rvalid_m[m] = 1'b0;
      for (int k = 0; k < 3; k++) begin
        route[m][k] = rvalid_s[k] & (rid_s[k][axi_pkg::IDS_BITS-1] ==
                      ((m == 0) ? axi_pkg::MASTER_0_ID : axi_pkg::MASTER_1_ID));
        if (route[m][k]) begin
          rid_m[m]    = rid_s[k][axi_pkg::ID_BITS-1:0];  // Tag stripped
          rdata_m[m]  = rdata_s[k];
          rresp_m[m]  = rresp_s[k];
          rlast_m[m]  = rlast_s[k];
          rvalid_m[m] = 1'b1;
        end
      end
    end
  end

  assign m0_rid    = rid_m[0];
  assign m0_rdata  = rdata_m[0];
  assign m0_rresp  = rresp_m[0];
  assign m0_rlast  = rlast_m[0];
  assign m0_rvalid = rvalid_m[0];
  assign m1_rid    = rid_m[1];
  assign m1_rdata  = rdata_m[1];
  assign m1_rresp  = rresp_m[1];
  assign m1_rlast  = rlast_m[1];
  assign m1_rvalid = rvalid_m[1];

  assign s0_rready = (route[0][0] & m0_rready) | (route[1][0] & m1_rready);
  assign s1_rready = (route[0][1] & m0_rready) | (route[1][1] & m1_rready);
  assign s2_rready = (route[0][2] & m0_rready) | (route[1][2] & m1_rready);

  // Last beat accepted
  assign m0_r_done = m0_rvalid & m0_rready & m0_rlast;
  assign m1_r_done = m1_rvalid & m1_rready & m1_rlast;
  assign s0_r_done = s0_rvalid & s0_rready & s0_rlast;
  assign s1_r_done = s1_rvalid & s1_rready & s1_rlast;
  assign s2_r_done = s2_rvalid & s2_rready & s2_rlast;

endmodule

`default_nettype wire

/* source/ar_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module ar_channel (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic [axi_pkg::ID_BITS-1:0]     m0_arid,
  input  logic [axi_pkg::ADDR_BITS-1:0]   m0_araddr,
  input  logic [axi_pkg::LEN_BITS-1:0]    m0_arlen,
  input  logic [axi_pkg::SIZE_BITS-1:0]   m0_arsize,
  input  logic [1:0]                      m0_arburst,
  input  logic                            m0_arvalid,
  output logic                            m0_arready,
  input  logic [axi_pkg::ID_BITS-1:0]     m1_arid,
  input  logic [axi_pkg::ADDR_BITS-1:0]   m1_araddr,
  input  logic [axi_pkg::LEN_BITS-1:0]    m1_arlen,
  input  logic [axi_pkg::SIZE_BITS-1:0]   m1_arsize,
  input  logic [1:0]                      m1_arburst,
  input  logic                            m1_arvalid,
  output logic                            m1_arready,
  output logic [axi_pkg::IDS_BITS-1:0]    s0_arid,
  output logic [axi_pkg::ADDR_BITS-1:0]   s0_araddr,
  output logic [axi_pkg::LEN_BITS-1:0]    s0_arlen,
  output logic [axi_pkg::SIZE_BITS-1:0]   s0_arsize,
  output logic [1:0]                      s0_arburst,
  output logic                            s0_arvalid,
  input  logic                            s0_arready,
  output logic [axi_pkg::IDS_BITS-1:0]    s1_arid,
  output logic [axi_pkg::ADDR_BITS-1:0]   s1_araddr,
  output logic [axi_pkg::LEN_BITS-1:0]    s1_arlen,
  output logic [axi_pkg::SIZE_BITS-1:0]   s1_arsize,
  output logic [1:0]                      s1_arburst,
  output logic                            s1_arvalid,
  input  logic                            s1_arready,
  output logic [axi_pkg::IDS_BITS-1:0]    s2_arid,
  output logic [axi_pkg::ADDR_BITS-1:0]   s2_araddr,
  output logic [axi_pkg::LEN_BITS-1:0]    s2_arlen,
  output logic [axi_pkg::SIZE_BITS-1:0]   s2_arsize,
  output logic [1:0]                      s2_arburst,
  output logic                            s2_arvalid,
  input  logic                            s2_arready,
  input  logic                            m0_r_done,
  input  logic                            m1_r_done,
  input  logic                            s0_r_done,
  input  logic                            s1_r_done,
  input  logic                            s2_r_done
);

  axi_pkg::arb_lock_t   arb_q, arb_d;
  axi_pkg::dec_result_t dec_m0, dec_m1, dec_sel;

  logic [2:0] lock_s;  // One outstanding burst per slave
  logic       lock_m0, lock_m1;
  logic       req_m0, req_m1;
  logic       sel_m1, sel_valid, sel_ready;
  logic [2:0] pick_s;

  logic [axi_pkg::IDS_BITS-1:0]  sel_id;
  logic [axi_pkg::ADDR_BITS-1:0] sel_addr;
  logic [axi_pkg::LEN_BITS-1:0]  sel_len;
  logic [axi_pkg::SIZE_BITS-1:0] sel_size;
  logic [1:0]                    sel_burst;

  assign dec_m0 = axi_pkg::addr_decode(m0_araddr);
  assign dec_m1 = axi_pkg::addr_decode(m1_araddr);

  // A request only counts when neither its master nor its target is busy
  assign req_m0 = m0_arvalid & ~lock_m0 & ~lock_s[dec_m0];
  assign req_m1 = m1_arvalid & ~lock_m1 & ~lock_s[dec_m1];

  always_comb begin
    sel_m1    = 1'b0;
    sel_valid = 1'b0;
    case (arb_q)
      axi_pkg::LOCK_M0: sel_valid = req_m0;
      axi_pkg::LOCK_M1: begin
        sel_m1    = 1'b1;
        sel_valid = req_m1;
      end
      default: begin
        sel_m1    = ~req_m0 & req_m1;  // M0 wins a tie
        sel_valid = req_m0 | req_m1;
      end
    endcase
  end

  always_comb begin
    arb_d = arb_q;
    if (arb_q == axi_pkg::LOCK_FREE) begin
      if (sel_valid & ~sel_ready) begin
        if (sel_m1) arb_d = axi_pkg::LOCK_M1;
        else arb_d = axi_pkg::LOCK_M0;
      end
    end else if (sel_valid & sel_ready) begin
      arb_d = axi_pkg::LOCK_FREE;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) arb_q <= axi_pkg::LOCK_FREE;
    else arb_q <= arb_d;
  end

  assign sel_id    = sel_m1 ? {axi_pkg::MASTER_1_ID, m1_arid} : {axi_pkg::MASTER_0_ID, m0_arid};
  assign sel_addr  = sel_m1 ? m1_araddr : m0_araddr;
  assign sel_len   = sel_m1 ? m1_arlen : m0_arlen;
  assign sel_size  = sel_m1 ? m1_arsize : m0_arsize;
  assign sel_burst = sel_m1 ? m1_arburst : m0_arburst;
  assign dec_sel   = sel_m1 ? dec_m1 : dec_m0;

  assign pick_s[0] = (dec_sel == axi_pkg::SLAVE_0);
  assign pick_s[1] = (dec_sel == axi_pkg::SLAVE_1);
  assign pick_s[2] = (dec_sel == axi_pkg::SLAVE_DEF);

  // Unselected slaves see zeros
  assign s0_arid    = pick_s[0] ? sel_id : '0;
  assign s0_araddr  = pick_s[0] ? sel_addr : '0;
  assign s0_arlen   = pick_s[0] ? sel_len : '0;
  assign s0_arsize  = pick_s[0] ? sel_size : '0;
  assign s0_arburst = pick_s[0] ? sel_burst : '0;
  assign s0_arvalid = pick_s[0] & sel_valid;

  assign s1_arid    = pick_s[1] ? sel_id : '0;
  assign s1_araddr  = pick_s[1] ? sel_addr : '0;
  assign s1_arlen   = pick_s[1] ? sel_len : '0;
  assign s1_arsize  = pick_s[1] ? sel_size : '0;
  assign s1_arburst = pick_s[1] ? sel_burst : '0;
  assign s1_arvalid = pick_s[1] & sel_valid;

  assign s2_arid    = pick_s[2] ? sel_id : '0;
  assign s2_araddr  = pick_s[2] ? sel_addr : '0;
  assign s2_arlen   = pick_s[2] ? sel_len : '0;
  assign s2_arsize  = pick_s[2] ? sel_size : '0;
  assign s2_arburst = pick_s[2] ? sel_burst : '0;
  assign s2_arvalid = pick_s[2] & sel_valid;

  assign sel_ready  = |(pick_s & {s2_arready, s1_arready, s0_arready});
  assign m0_arready = sel_valid & ~sel_m1 & sel_ready;
  assign m1_arready = sel_valid & sel_m1 & sel_ready;

  // Set at the address handshake, cleared by the RLAST handshake
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_m0 <= 1'b0;
      lock_m1 <= 1'b0;
      lock_s  <= 3'b000;
    end else begin
      lock_m0   <= lock_m0 ? ~m0_r_done : (m0_arvalid & m0_arready);
      lock_m1   <= lock_m1 ? ~m1_r_done : (m1_arvalid & m1_arready);
      lock_s[0] <= lock_s[0] ? ~s0_r_done : (s0_arvalid & s0_arready);
      lock_s[1] <= lock_s[1] ? ~s1_r_done : (s1_arvalid & s1_arready);
      lock_s[2] <= lock_s[2] ? ~s2_r_done : (s2_arvalid & s2_arready);
    end
  end

endmodule

`default_nettype wire

/* source/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  localparam int ID_BITS   = 4;
  localparam int IDS_BITS  = 5;  // Master tag + master ID
  localparam int ADDR_BITS = 32;
  localparam int LEN_BITS  = 4;
  localparam int SIZE_BITS = 3;

  // Tag placed in the upper bit of the slave-side ID
  localparam logic MASTER_0_ID = 1'b0;
  localparam logic MASTER_1_ID = 1'b1;

  localparam logic [ADDR_BITS-1:0] S0_BASE = 32'h0000_0000;
  localparam logic [ADDR_BITS-1:0] S0_LAST = 32'h0000_FFFF;
  localparam logic [ADDR_BITS-1:0] S1_BASE = 32'h0001_0000;
  localparam logic [ADDR_BITS-1:0] S1_LAST = 32'h0001_FFFF;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  typedef enum logic [1:0] {
    LOCK_FREE,
    LOCK_M0,
    LOCK_M1
  } arb_lock_t;

  typedef enum logic [1:0] {
    SLAVE_0,
    SLAVE_1,
    SLAVE_DEF
  } dec_result_t;

  typedef enum logic {
    DS_IDLE,
    DS_BURST
  } ds_state_t;

  // Anything outside the two windows goes to the default slave
  function automatic dec_result_t addr_decode(input logic [ADDR_BITS-1:0] addr);
    if (addr >= S0_BASE && addr <= S0_LAST) return SLAVE_0;
    if (addr >= S1_BASE && addr <= S1_LAST) return SLAVE_1;
    return SLAVE_DEF;
  endfunction

endpackage

`default_nettype wire
